// ==== all.f ====
+incdir+.
soc_bus_pkg.sv
soc_timer_pkg.sv
bus_arbiter.sv
bus_decoder.sv
boot_rom.sv
l2_spm.sv
clint_timer.sv
debug_req_gate.sv
soc_top.sv
tb_soc.sv

// ==== run.sh ====
#!/bin/sh
# build tb_soc with verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc \
  -f all.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_soc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Everything OK$" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== tb_soc.sv ====
// ------------------------------
// soc_top testbench, checks run as concurrent assertions
// l2 words get a full write before partial writes are compared
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module tb_soc;

  localparam logic [31:0] MSIP_A     = {`REGION_CLINT, 28'h000_0000};
  localparam logic [31:0] MTIMECMP_A = {`REGION_CLINT, 28'h000_4000};
  localparam logic [31:0] MTIME_A    = {`REGION_CLINT, 28'h000_bff8};

  logic        clk_i, ndmreset_n, rtc_i, debug_req_i;
  logic        core_req_i, core_we_i, dbg_req_i, dbg_we_i;
  logic [31:0] core_addr_i, dbg_addr_i;
  logic [63:0] core_wdata_i, dbg_wdata_i, core_rdata_o, dbg_rdata_o;
  logic [7:0]  core_be_i, dbg_be_i;
  logic        core_gnt_o, core_rvalid_o, dbg_gnt_o, dbg_rvalid_o;
  logic        debug_req_o, timer_irq_o, ipi_o;

  // expected response per master, latched on its grant
  logic        core_took_q, dbg_took_q, gnt_seen_q, last_dbg_q;
  logic [1:0]  core_mode, dbg_mode, core_mode_q, dbg_mode_q;
  logic [63:0] core_exp, dbg_exp, core_exp_q, dbg_exp_q;
  logic [31:0] rng;
  logic [63:0] l2_model [8];
  logic [9:0]  l2_idx [8];
  int          cyc_q, errors, tests, failed;

  soc_top i_dut (.*);

  always #4 clk_i = ~clk_i;

  always begin
    repeat (10) @(negedge clk_i);
    rtc_i = ~rtc_i;
  end

  always @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      core_took_q <= 1'b0;
      dbg_took_q  <= 1'b0;
      gnt_seen_q  <= 1'b0;
      last_dbg_q  <= 1'b0;
      core_mode_q <= 2'd0;
      dbg_mode_q  <= 2'd0;
      cyc_q       <= 0;
    end else begin
      core_took_q <= core_gnt_o;
      dbg_took_q  <= dbg_gnt_o;
      cyc_q       <= cyc_q + 1;
      if (core_gnt_o || dbg_gnt_o) begin
        gnt_seen_q <= 1'b1;
        last_dbg_q <= dbg_gnt_o;
      end
      if (core_gnt_o) begin
        core_mode_q <= core_mode;
        core_exp_q  <= core_exp;
      end
      if (dbg_gnt_o) begin
        dbg_mode_q <= dbg_mode;
        dbg_exp_q  <= dbg_exp;
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  a_reset_vals : assert property (@(posedge clk_i) !ndmreset_n |->
    !(core_gnt_o || dbg_gnt_o || core_rvalid_o || dbg_rvalid_o || ipi_o || debug_req_o ||
      timer_irq_o)) else flag_error("an output was high during reset");
  a_gnt_excl : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !(core_gnt_o && dbg_gnt_o)) else flag_error("both masters granted in one cycle");
  a_any_gnt : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (core_req_i || dbg_req_i) |-> (core_gnt_o || dbg_gnt_o))
    else flag_error("a request was left without any grant");
  // both requesting, the master granted last time has to wait
  a_alternate : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    core_req_i && dbg_req_i && gnt_seen_q |-> dbg_gnt_o != last_dbg_q)
    else flag_error("both masters requested and the grant did not alternate");
  a_core_rv : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    core_gnt_o |=> core_rvalid_o) else flag_error("core rvalid missing after its grant");
  a_dbg_rv : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    dbg_gnt_o |=> dbg_rvalid_o) else flag_error("debug rvalid missing after its grant");
  a_core_rv_src : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    core_rvalid_o |-> $past(core_gnt_o)) else flag_error("core rvalid without a grant");
  a_dbg_rv_src : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    dbg_rvalid_o |-> $past(dbg_gnt_o)) else flag_error("debug rvalid without a grant");
  a_core_eq : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    core_rvalid_o && core_mode_q == 2'd1 |-> core_rdata_o == core_exp_q)
    else flag_error($sformatf("error core_rdata_o: got %h, expected %h",
      $sampled(core_rdata_o), $sampled(core_exp_q)));
  a_dbg_eq : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    dbg_rvalid_o && dbg_mode_q == 2'd1 |-> dbg_rdata_o == dbg_exp_q)
    else flag_error($sformatf("error dbg_rdata_o: got %h, expected %h",
      $sampled(dbg_rdata_o), $sampled(dbg_exp_q)));
  // mode 2 is a lower bound, used for mtime
  a_core_ge : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    core_rvalid_o && core_mode_q == 2'd2 |-> core_rdata_o >= core_exp_q)
    else flag_error($sformatf("error core_rdata_o: got %h, expected at least %h",
      $sampled(core_rdata_o), $sampled(core_exp_q)));
  a_dbg_ge : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    dbg_rvalid_o && dbg_mode_q == 2'd2 |-> dbg_rdata_o >= dbg_exp_q)
    else flag_error($sformatf("error dbg_rdata_o: got %h, expected at least %h",
      $sampled(dbg_rdata_o), $sampled(dbg_exp_q)));
  a_debug_gate : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    debug_req_o == (debug_req_i && cyc_q >= `DMI_DEL_CYCLES))
    else flag_error($sformatf("error debug_req_o: got %h, expected %h", $sampled(debug_req_o),
      $sampled(debug_req_i && cyc_q >= `DMI_DEL_CYCLES)));

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic flag_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  function automatic logic [31:0] rand_word();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  function automatic logic [31:0] rom_addr(input logic [7:0] k);
    return {`REGION_ROM, 17'd0, k, 3'd0};
  endfunction

  function automatic logic [63:0] rom_word(input logic [7:0] k);
    return {`ROM_PATTERN ^ {24'd0, k}, `ROM_PATTERN ^ {24'd0, k}};
  endfunction

  function automatic logic [31:0] l2_addr(input logic [9:0] idx);
    return {`REGION_L2, 15'd0, idx, 3'd0};
  endfunction

  function automatic logic [63:0] merge(input logic [63:0] old, input logic [63:0] nw,
                                        input logic [7:0] be);
    logic [63:0] res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) res[b*8 +: 8] = nw[b*8 +: 8];
    end
    return res;
  endfunction

  // one access on master m, returns at the falling edge after its grant
  task automatic access(input logic m, input logic [31:0] addr, input logic we,
                        input logic [63:0] wdata, input logic [7:0] be,
                        input logic [1:0] mode, input logic [63:0] exp,
                        output logic [63:0] rdata);
    int   t;
    logic got;
    t = 0;
    got = 1'b0;
    if (m) begin
      dbg_req_i   = 1'b1;
      dbg_addr_i  = addr;
      dbg_we_i    = we;
      dbg_wdata_i = wdata;
      dbg_be_i    = be;
      dbg_mode    = mode;
      dbg_exp     = exp;
    end else begin
      core_req_i   = 1'b1;
      core_addr_i  = addr;
      core_we_i    = we;
      core_wdata_i = wdata;
      core_be_i    = be;
      core_mode    = mode;
      core_exp     = exp;
    end
    while (!got && t < 20) begin
      @(negedge clk_i);
      t++;
      got = m ? dbg_took_q : core_took_q;
    end
    if (m) dbg_req_i = 1'b0;
    else core_req_i = 1'b0;
    rdata = m ? dbg_rdata_o : core_rdata_o;
    if (!got) flag_error($sformatf("master %0d was not granted within 20 cycles", m));
  endtask

  task automatic finish_test(input string name, input int errs_before);
    // last response is checked on the next rising edge
    @(negedge clk_i);
    tests++;
    if (errors != errs_before) failed++;
    $display("test %0d %s: %s", tests, name, errors == errs_before ? "passed" : "failed");
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    logic [63:0] rd, wd;
    logic [7:0]  k, be;
    logic [2:0]  p;
    int          e0, t;
    rng = 32'h68bc_8675;
    errors = 0;
    tests = 0;
    failed = 0;
    clk_i = 1'b0;
    rtc_i = 1'b0;
    ndmreset_n = 1'b1;
    debug_req_i = 1'b1;
    core_req_i = 1'b0;
    core_addr_i = '0;
    core_we_i = 1'b0;
    core_wdata_i = '0;
    core_be_i = '0;
    dbg_req_i = 1'b0;
    dbg_addr_i = '0;
    dbg_we_i = 1'b0;
    dbg_wdata_i = '0;
    dbg_be_i = '0;
    core_mode = 2'd0;
    dbg_mode = 2'd0;
    core_exp = '0;
    dbg_exp = '0;
    #1 ndmreset_n = 1'b0;
    repeat (10) @(negedge clk_i);
    ndmreset_n = 1'b1;

    // debug request held high since reset
    e0 = errors;
    t = 0;
    while (!debug_req_o && t < `DMI_DEL_CYCLES + 20) begin
      @(negedge clk_i);
      t++;
    end
    if (!debug_req_o) flag_error("debug_req_o never rose after the blanking window");
    // output follows the input once the window is over
    debug_req_i = 1'b0;
    repeat (2) @(negedge clk_i);
    debug_req_i = 1'b1;
    finish_test("debug request window", e0);

    e0 = errors;
    for (int j = 0; j < 8; j++) begin
      k = 8'(rand_word());
      access(j[0], rom_addr(k), 1'b0, '0, '0, 2'd1, rom_word(k), rd);
    end
    k = 8'(rand_word());
    access(1'b0, rom_addr(k), 1'b1, {rand_word(), rand_word()}, 8'hff, 2'd1, '0, rd);
    access(1'b1, rom_addr(k), 1'b0, '0, '0, 2'd1, rom_word(k), rd);
    finish_test("boot rom", e0);

    // l2 pool of 8 distinct words, written through one master, read through the other
    e0 = errors;
    for (int j = 0; j < 8; j++) begin
      l2_idx[j] = {7'(rand_word()), 3'(j)};
      l2_model[j] = {rand_word(), rand_word()};
      access(1'b0, l2_addr(l2_idx[j]), 1'b1, l2_model[j], 8'hff, 2'd0, '0, rd);
    end
    for (int j = 0; j < 16; j++) begin
      p = 3'(rand_word());
      wd = {rand_word(), rand_word()};
      be = 8'(rand_word());
      l2_model[p] = merge(l2_model[p], wd, be);
      access(j[0], l2_addr(l2_idx[p]), 1'b1, wd, be, 2'd0, '0, rd);
      access(!j[0], l2_addr(l2_idx[p]), 1'b0, '0, '0, 2'd1, l2_model[p], rd);
    end
    finish_test("l2 scratchpad", e0);

    e0 = errors;
    fork
      begin : core_side
        logic [7:0]  ck;
        logic [63:0] cr;
        for (int a = 0; a < 6; a++) begin
          ck = 8'(rand_word());
          access(1'b0, rom_addr(ck), 1'b0, '0, '0, 2'd1, rom_word(ck), cr);
        end
      end
      begin : dbg_side
        logic [7:0]  dk;
        logic [63:0] dr;
        for (int a = 0; a < 6; a++) begin
          dk = 8'(rand_word());
          access(1'b1, rom_addr(dk), 1'b0, '0, '0, 2'd1, rom_word(dk), dr);
        end
      end
    join
    finish_test("contention", e0);

    // mtime must not go back between reads
    e0 = errors;
    rd = '0;
    for (int j = 0; j < 4; j++) begin
      access(j[0], MTIME_A, 1'b0, '0, '0, 2'd2, rd, rd);
      repeat (45) @(negedge clk_i);
    end
    access(1'b0, MTIME_A, 1'b1, '0, 8'hff, 2'd0, '0, rd);
    access(1'b0, MTIMECMP_A, 1'b1, 64'd3, 8'hff, 2'd0, '0, rd);
    access(1'b1, MTIMECMP_A, 1'b0, '0, '0, 2'd1, 64'd3, rd);
    t = 0;
    while (!timer_irq_o && t < 400) begin
      @(negedge clk_i);
      t++;
    end
    if (!timer_irq_o) flag_error("timer_irq_o did not rise after mtimecmp was lowered");
    access(1'b0, MSIP_A, 1'b1, 64'd1, 8'h01, 2'd0, '0, rd);
    access(1'b1, MSIP_A, 1'b0, '0, '0, 2'd1, 64'd1, rd);
    t = 0;
    while (!ipi_o && t < 4) begin
      @(negedge clk_i);
      t++;
    end
    if (!ipi_o) flag_error("ipi_o did not rise after msip was set");
    access(1'b1, MSIP_A, 1'b1, 64'd0, 8'h01, 2'd0, '0, rd);
    t = 0;
    while (ipi_o && t < 4) begin
      @(negedge clk_i);
      t++;
    end
    if (ipi_o) flag_error("ipi_o stayed high after msip was cleared");
    finish_test("timer", e0);

    e0 = errors;
    access(1'b0, {4'h4, 28'(rand_word())}, 1'b0, '0, '0, 2'd1, '0, rd);
    access(1'b1, {4'hc, 28'(rand_word())}, 1'b0, '0, '0, 2'd1, '0, rd);
    access(1'b0, {4'h4, 28'(rand_word())}, 1'b1, {rand_word(), rand_word()}, 8'hff, 2'd1,
           '0, rd);
    finish_test("unmapped region", e0);

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== soc_top.sv ====
// ------------------------------
// core and debug masters on one bus, rom / clint / l2 behind it
// both masters share one rdata, rvalid tells whose it is
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module soc_top (
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic                    rtc_i,
  input  logic                    core_req_i,
  input  logic [`BUS_AW-1:0]      core_addr_i,
  input  logic                    core_we_i,
  input  soc_bus_pkg::bus_data_t  core_wdata_i,
  input  soc_bus_pkg::bus_be_t    core_be_i,
  output logic                    core_gnt_o,
  output logic                    core_rvalid_o,
  output soc_bus_pkg::bus_data_t  core_rdata_o,
  input  logic                    dbg_req_i,
  input  logic [`BUS_AW-1:0]      dbg_addr_i,
  input  logic                    dbg_we_i,
  input  soc_bus_pkg::bus_data_t  dbg_wdata_i,
  input  soc_bus_pkg::bus_be_t    dbg_be_i,
  output logic                    dbg_gnt_o,
  output logic                    dbg_rvalid_o,
  output soc_bus_pkg::bus_data_t  dbg_rdata_o,
  input  logic                    debug_req_i,
  output logic                    debug_req_o,
  output logic                    timer_irq_o,
  output logic                    ipi_o
);
  import soc_bus_pkg::*;

  // arbiter to decoder
  logic      arb_req, arb_we, arb_mid;
  bus_addr_u arb_addr;
  bus_data_t arb_wdata;
  bus_be_t   arb_be;

  // decoder to targets
  logic               rom_req, l2_req, clint_req, tgt_we;
  logic [`BUS_AW-5:0] tgt_offset;
  bus_data_t          tgt_wdata, rom_rdata, l2_rdata, clint_rdata, bus_rdata;
  bus_be_t            tgt_be;

  assign core_rdata_o = bus_rdata;
  assign dbg_rdata_o  = bus_rdata;

  bus_arbiter i_arbiter (
    .clk_i, .ndmreset_n,
    .core_req_i, .core_addr_i, .core_we_i, .core_wdata_i, .core_be_i, .core_gnt_o,
    .dbg_req_i, .dbg_addr_i, .dbg_we_i, .dbg_wdata_i, .dbg_be_i, .dbg_gnt_o,
    .req_o   ( arb_req   ),
    .addr_o  ( arb_addr  ),
    .we_o    ( arb_we    ),
    .wdata_o ( arb_wdata ),
    .be_o    ( arb_be    ),
    .mid_o   ( arb_mid   )
  );

  bus_decoder i_decoder (
    .clk_i, .ndmreset_n,
    .req_i   ( arb_req   ),
    .addr_i  ( arb_addr  ),
    .we_i    ( arb_we    ),
    .wdata_i ( arb_wdata ),
    .be_i    ( arb_be    ),
    .mid_i   ( arb_mid   ),
    .rom_req_o     ( rom_req     ),
    .l2_req_o      ( l2_req      ),
    .clint_req_o   ( clint_req   ),
    .offset_o      ( tgt_offset  ),
    .we_o          ( tgt_we      ),
    .wdata_o       ( tgt_wdata   ),
    .be_o          ( tgt_be      ),
    .rom_rdata_i   ( rom_rdata   ),
    .l2_rdata_i    ( l2_rdata    ),
    .clint_rdata_i ( clint_rdata ),
    .core_rvalid_o, .dbg_rvalid_o,
    .rdata_o       ( bus_rdata   )
  );

  boot_rom i_boot_rom (
    .clk_i,
    .req_i    ( rom_req    ),
    .offset_i ( tgt_offset ),
    .rdata_o  ( rom_rdata  )
  );

  l2_spm i_l2_spm (
    .clk_i,
    .req_i    ( l2_req     ),
    .we_i     ( tgt_we     ),
    .offset_i ( tgt_offset ),
    .wdata_i  ( tgt_wdata  ),
    .be_i     ( tgt_be     ),
    .rdata_o  ( l2_rdata   )
  );

  clint_timer i_clint (
    .clk_i, .ndmreset_n, .rtc_i,
    .req_i    ( clint_req   ),
    .we_i     ( tgt_we      ),
    .offset_i ( tgt_offset  ),
    .wdata_i  ( tgt_wdata   ),
    .be_i     ( tgt_be      ),
    .rdata_o  ( clint_rdata ),
    .timer_irq_o, .ipi_o
  );

  debug_req_gate i_dbg_gate (
    .clk_i, .ndmreset_n, .debug_req_i, .debug_req_o
  );

endmodule

`default_nettype wire

// ==== debug_req_gate.sv ====
// ------------------------------
// debug request blanked for DMI_DEL_CYCLES clocks after reset
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module debug_req_gate (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CntW = $clog2(`DMI_DEL_CYCLES + 1);

  logic [CntW-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CntW'(`DMI_DEL_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // let boot code run before the core can be halted
  assign debug_req_o = (cnt_q == '0) ? debug_req_i : 1'b0;

endmodule

`default_nettype wire

// ==== clint_timer.sv ====
// ------------------------------
// mtime ticks on every second rtc_i rising edge after a 2-flop sync
// rtc_i must stay below a quarter of the clk_i rate
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module clint_timer (
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic                    rtc_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [`BUS_AW-5:0]      offset_i,
  input  soc_bus_pkg::bus_data_t  wdata_i,
  input  soc_bus_pkg::bus_be_t    be_i,
  output soc_bus_pkg::bus_data_t  rdata_o,
  output logic                    timer_irq_o,
  output logic                    ipi_o
);
  import soc_bus_pkg::*;
  import soc_timer_pkg::*;

  logic   rtc_meta_q, rtc_sync_q, rtc_prev_q, div_q, tick;
  logic   msip_q, sel_msip, sel_cmp, sel_mtime, mtime_we;
  mtime_t mtime_q, mtimecmp_q;

  function automatic mtime_t merge_bytes(mtime_t old_val, bus_data_t wdata, bus_be_t be);
    mtime_t res;
    res = old_val;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

  // ------------------------------
  // rtc sync and divide by two
  // ------------------------------
  assign tick = rtc_sync_q & ~rtc_prev_q & div_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_meta_q <= 1'b0;
      rtc_sync_q <= 1'b0;
      rtc_prev_q <= 1'b0;
      div_q      <= 1'b0;
    end else begin
      rtc_meta_q <= rtc_i;
      rtc_sync_q <= rtc_meta_q;
      rtc_prev_q <= rtc_sync_q;
      if (rtc_sync_q && !rtc_prev_q) div_q <= ~div_q;
    end
  end

  // ------------------------------
  // registers
  // ------------------------------
  assign sel_msip  = offset_i[15:0] == MSIP_OFF;
  assign sel_cmp   = offset_i[15:0] == MTIMECMP_OFF;
  assign sel_mtime = offset_i[15:0] == MTIME_OFF;
  assign mtime_we  = req_i & we_i & sel_mtime;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      if (mtime_we) mtime_q <= merge_bytes(mtime_q, wdata_i, be_i);
      else if (tick) mtime_q <= mtime_q + 64'd1;
      if (req_i && we_i && sel_cmp) mtimecmp_q <= merge_bytes(mtimecmp_q, wdata_i, be_i);
      if (req_i && we_i && sel_msip && be_i[0]) msip_q <= wdata_i[0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (sel_msip) rdata_o <= {63'd0, msip_q};
      else if (sel_cmp) rdata_o <= mtimecmp_q;
      else if (sel_mtime) rdata_o <= mtime_q;
      else rdata_o <= '0;
    end
  end

  assign timer_irq_o = mtime_q >= mtimecmp_q;
  assign ipi_o       = msip_q;

  a_mtime_mono : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !mtime_we |=> mtime_q >= $past(mtime_q)) else $error("mtime went backwards");

endmodule

`default_nettype wire

// ==== l2_spm.sv ====
// ------------------------------
// single-port scratchpad, contents undefined after power-up
// read data is the old word on a write
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module l2_spm (
  input  logic                    clk_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [`BUS_AW-5:0]      offset_i,
  input  soc_bus_pkg::bus_data_t  wdata_i,
  input  soc_bus_pkg::bus_be_t    be_i,
  output soc_bus_pkg::bus_data_t  rdata_o
);

  localparam int unsigned IdxW = $clog2(`L2_WORDS);

  logic [`BUS_DW-1:0] mem [`L2_WORDS];
  logic [IdxW-1:0]    idx;

  assign idx = offset_i[IdxW+2:3];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // byte lanes
        for (int b = 0; b < `BUS_DW/8; b++) begin
          if (be_i[b]) begin
            mem[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end
      rdata_o <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// ==== boot_rom.sv ====
// ------------------------------
// pattern rom, word index from offset bits above the byte lane
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module boot_rom (
  input  logic                    clk_i,
  input  logic                    req_i,
  input  logic [`BUS_AW-5:0]      offset_i,
  output soc_bus_pkg::bus_data_t  rdata_o
);

  localparam int unsigned IdxW = $clog2(`ROM_WORDS);

  logic [IdxW-1:0] idx;
  logic [31:0]     word;

  assign idx  = offset_i[IdxW+2:3];
  assign word = `ROM_PATTERN ^ 32'(idx);

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= {word, word};
    end
  end

endmodule

`default_nettype wire

// ==== bus_decoder.sv ====
// ------------------------------
// region decode and response return, rvalid one cycle after grant
// rom writes and unmapped regions answer with zero data
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module bus_decoder (
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic                    req_i,
  input  soc_bus_pkg::bus_addr_u  addr_i,
  input  logic                    we_i,
  input  soc_bus_pkg::bus_data_t  wdata_i,
  input  soc_bus_pkg::bus_be_t    be_i,
  input  logic                    mid_i,
  output logic                    rom_req_o,
  output logic                    l2_req_o,
  output logic                    clint_req_o,
  output logic [`BUS_AW-5:0]      offset_o,
  output logic                    we_o,
  output soc_bus_pkg::bus_data_t  wdata_o,
  output soc_bus_pkg::bus_be_t    be_o,
  input  soc_bus_pkg::bus_data_t  rom_rdata_i,
  input  soc_bus_pkg::bus_data_t  l2_rdata_i,
  input  soc_bus_pkg::bus_data_t  clint_rdata_i,
  output logic                    core_rvalid_o,
  output logic                    dbg_rvalid_o,
  output soc_bus_pkg::bus_data_t  rdata_o
);
  import soc_bus_pkg::*;

  region_e rgn_d, rgn_q;
  logic    valid_q, mid_q;

  // ------------------------------
  // request side
  // ------------------------------
  always_comb begin
    unique case (addr_i.fld.region)
      `REGION_ROM:   rgn_d = we_i ? RGN_NONE : RGN_ROM;
      `REGION_CLINT: rgn_d = RGN_CLINT;
      `REGION_L2:    rgn_d = RGN_L2;
      default:       rgn_d = RGN_NONE;
    endcase
  end

  assign rom_req_o   = req_i && (rgn_d == RGN_ROM);
  assign l2_req_o    = req_i && (rgn_d == RGN_L2);
  assign clint_req_o = req_i && (rgn_d == RGN_CLINT);
  assign offset_o    = addr_i.fld.offset;
  assign we_o        = we_i;
  assign wdata_o     = wdata_i;
  assign be_o        = be_i;

  // ------------------------------
  // response side
  // ------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
      mid_q   <= 1'b0;
      rgn_q   <= RGN_NONE;
    end else begin
      valid_q <= req_i;
      mid_q   <= mid_i;
      rgn_q   <= rgn_d;
    end
  end

  assign core_rvalid_o = valid_q & ~mid_q;
  assign dbg_rvalid_o  = valid_q & mid_q;

  always_comb begin
    unique case (rgn_q)
      RGN_ROM:   rdata_o = rom_rdata_i;
      RGN_L2:    rdata_o = l2_rdata_i;
      RGN_CLINT: rdata_o = clint_rdata_i;
      default:   rdata_o = '0;
    endcase
  end

  a_rvalid_req : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (core_rvalid_o || dbg_rvalid_o) |-> $past(req_i))
    else $error("rvalid without a request");

endmodule

`default_nettype wire

// ==== bus_arbiter.sv ====
// ------------------------------
// two-master round robin, grant is combinational
// masters must hold their request until granted
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module bus_arbiter (
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic                    core_req_i,
  input  logic [`BUS_AW-1:0]      core_addr_i,
  input  logic                    core_we_i,
  input  soc_bus_pkg::bus_data_t  core_wdata_i,
  input  soc_bus_pkg::bus_be_t    core_be_i,
  output logic                    core_gnt_o,
  input  logic                    dbg_req_i,
  input  logic [`BUS_AW-1:0]      dbg_addr_i,
  input  logic                    dbg_we_i,
  input  soc_bus_pkg::bus_data_t  dbg_wdata_i,
  input  soc_bus_pkg::bus_be_t    dbg_be_i,
  output logic                    dbg_gnt_o,
  output logic                    req_o,
  output soc_bus_pkg::bus_addr_u  addr_o,
  output logic                    we_o,
  output soc_bus_pkg::bus_data_t  wdata_o,
  output soc_bus_pkg::bus_be_t    be_o,
  output logic                    mid_o
);

  // 1 when the debug master won the last grant
  logic last_dbg_q;

  assign core_gnt_o = core_req_i & (~dbg_req_i | last_dbg_q);
  assign dbg_gnt_o  = dbg_req_i & (~core_req_i | ~last_dbg_q);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      last_dbg_q <= 1'b1;
    end else if (core_gnt_o || dbg_gnt_o) begin
      last_dbg_q <= dbg_gnt_o;
    end
  end

  // single stream towards the decoder
  assign req_o   = core_gnt_o | dbg_gnt_o;
  assign mid_o   = dbg_gnt_o;
  assign addr_o  = dbg_gnt_o ? dbg_addr_i  : core_addr_i;
  assign we_o    = dbg_gnt_o ? dbg_we_i    : core_we_i;
  assign wdata_o = dbg_gnt_o ? dbg_wdata_i : core_wdata_i;
  assign be_o    = dbg_gnt_o ? dbg_be_i    : core_be_i;

  a_gnt_excl : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !(core_gnt_o && dbg_gnt_o)) else $error("both masters granted");

endmodule

`default_nettype wire

// ==== soc_timer_pkg.sv ====
// ------------------------------
// clint register map, offsets within the timer region
// only offset bits 15:0 are decoded
// ------------------------------
`default_nettype none

package soc_timer_pkg;

  typedef logic [63:0] mtime_t;

  localparam logic [15:0] MSIP_OFF     = 16'h0000;
  localparam logic [15:0] MTIMECMP_OFF = 16'h4000;
  localparam logic [15:0] MTIME_OFF    = 16'hbff8;

endpackage

`default_nettype wire

// ==== soc_bus_pkg.sv ====
// ------------------------------
// shared bus types for masters, decoder and targets
// address union needs BUS_AW of at least 5
// ------------------------------
`default_nettype none
`include "soc_cfg.svh"

package soc_bus_pkg;

  typedef logic [`BUS_DW-1:0]   bus_data_t;
  typedef logic [`BUS_DW/8-1:0] bus_be_t;

  // region nibble on top, byte offset below
  typedef struct packed {
    logic [3:0]         region;
    logic [`BUS_AW-5:0] offset;
  } bus_addr_fields_t;

  typedef union packed { logic [`BUS_AW-1:0] raw; bus_addr_fields_t fld; } bus_addr_u;

  // decoded target, NONE also covers rom writes
  typedef enum logic [1:0] {RGN_ROM, RGN_CLINT, RGN_L2, RGN_NONE} region_e;

endpackage

`default_nettype wire

// ==== soc_cfg.svh ====
// ------------------------------
// bus widths, region codes and fixed sizes for the whole SoC slice
// region code is the top address nibble, the rest is the offset
// ------------------------------
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// bus geometry
`define BUS_AW 32
`define BUS_DW 64

// top-nibble region codes
`define REGION_ROM   4'h1
`define REGION_CLINT 4'h2
`define REGION_L2    4'h8

// memory depths in 64-bit words
`define ROM_WORDS 256
`define L2_WORDS  1024

// debug request blanking after reset, in clk_i cycles
`define DMI_DEL_CYCLES 500

// rom word k holds this xor k in both halves
`define ROM_PATTERN 32'hb007_c0de

`endif
